// ==== verification/lsm_tests.txt ====
# Columns: op (1 write, 0 read), addr (hex, bank in bits 4:3), wdata (hex), pwr_enable_b, pgcb_isol_en,
# hold cycles after ack, expected rdata (hex, held from the last read), expected parity_err
1 00 1234 0 0 0 0000 0
0 00 0000 0 0 0 1234 0
1 0D A5A5 0 0 2 1234 0
0 0D 0000 0 0 1 A5A5 0
1 16 0001 0 0 0 A5A5 0
1 1F FFFF 0 0 0 A5A5 0
0 16 0000 0 0 0 0001 0
0 1F 0000 0 0 3 FFFF 0
# Same entry in every bank
1 03 1111 0 0 0 FFFF 0
1 0B 2222 0 0 0 FFFF 0
1 13 3333 0 0 0 FFFF 0
1 1B 4444 0 0 0 FFFF 0
0 03 0000 0 0 0 1111 0
0 0B 0000 0 0 0 2222 0
0 13 0000 0 0 0 3333 0
0 1B 0000 0 0 0 4444 0
# Sleeping banks clamp reads and drop writes
0 0B 0000 1 0 0 0000 1
1 0B BEEF 1 0 0 0000 1
0 0B 0000 0 0 0 2222 0
# Isolation clamps reads only
0 13 0000 0 1 0 0000 1
1 04 CAFE 0 1 0 0000 1
0 04 0000 0 0 0 CAFE 0
0 13 0000 0 0 2 3333 0
0 00 0000 0 0 0 1234 0

// ==== all.f ====
rtl/lsm_geom_pkg.sv
rtl/lsm_ctrl_pkg.sv
rtl/lsm_rf_bank.sv
rtl/lsm_req_decoder.sv
rtl/lsm_rsp_collector.sv
rtl/lsm_subsys_top.sv
verification/tb_lsm_subsys.sv

// ==== Makefile ====
# Verilator build and run for the storage subsystem

VERILATOR ?= verilator
TOP       ?= tb_lsm_subsys
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
DATA := verification/lsm_tests.txt
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN) $(DATA)
	./$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_lsm_subsys.sv ====
// Storage subsystem testbench

`timescale 1ns/1ps

module tb_lsm_subsys
    import lsm_geom_pkg::*;
    import lsm_ctrl_pkg::*;
();

    // --------------------
    // Test record
    // --------------------

    // One line of the tests file
    typedef struct packed {
        logic       write;
        cmd_addr_t  addr;
        payload_t   wdata;
        logic       pwr;
        logic       isol;
        logic [7:0] hold;
        payload_t   rdata;
        logic       perr;
    } test_t;

    // Edges from req sampled high to ack high
    localparam int ack_latency     = 3;
    localparam int cycles_per_test = 20;
    localparam int limit_margin    = 50;

    logic      clk;
    logic      rst_n;
    logic      req;
    logic      write;
    cmd_addr_t addr;
    payload_t  wdata;
    logic      ack;
    payload_t  rdata;
    logic      parity_err;
    logic      pwr_enable_b;
    logic      pgcb_isol_en;
    logic      pwr_enable_b_out;

    test_t tests [$];
    int    errors      = 0;
    int    checks      = 0;
    int    cycles      = 0;
    int    cycle_limit = 0;

    lsm_subsys_top i_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .req              (req),
        .write            (write),
        .addr             (addr),
        .wdata            (wdata),
        .ack              (ack),
        .rdata            (rdata),
        .parity_err       (parity_err),
        .pwr_enable_b     (pwr_enable_b),
        .pgcb_isol_en     (pgcb_isol_en),
        .pwr_enable_b_out (pwr_enable_b_out)
    );

    // 100 ns clock period
    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Watchdog that ends the run once the limit set from the tests file is reached
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    // --------------------
    // Helpers
    // --------------------

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] time %0t: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    // Lines starting with # are comments, blank lines are skipped
    task automatic load_tests();
        int          fd;
        int          n;
        int          f_hold;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_pwr;
        logic [31:0] f_isol;
        logic [31:0] f_rdata;
        logic [31:0] f_perr;
        test_t       t;
        fd = $fopen("verification/lsm_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test file verification/lsm_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %d %h %h", f_op, f_addr, f_wdata,
                                f_pwr, f_isol, f_hold, f_rdata, f_perr);
                    if (n == 8) begin
                        t.write = f_op[0];
                        t.addr  = f_addr[addr_w-1:0];
                        t.wdata = f_wdata[payload_w-1:0];
                        t.pwr   = f_pwr[0];
                        t.isol  = f_isol[0];
                        t.hold  = f_hold[7:0];
                        t.rdata = f_rdata[payload_w-1:0];
                        t.perr  = f_perr[0];
                        tests.push_back(t);
                    end else begin
                        $display("Malformed line in the test file: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Power setup, then one full four-phase transfer
    task automatic run_test(input int idx);
        test_t t;
        int    edges;
        t = tests[idx];
        @(posedge clk);
        pwr_enable_b <= t.pwr;
        pgcb_isol_en <= t.isol;
        // The enable ripples through one flop per bank
        repeat (num_banks + 1) @(posedge clk);
        @(negedge clk);
        check_value(32'(pwr_enable_b_out), 32'(t.pwr),
                    $sformatf("test %0d enable chain output", idx));
        @(posedge clk);
        req   <= 1'b1;
        write <= t.write;
        addr  <= t.addr;
        wdata <= t.wdata;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (!ack);
        // The first counted edge is the one that samples req high
        check_value(32'(edges), 32'(ack_latency + 1), $sformatf("test %0d ack latency", idx));
        // Read results are held across writes, so both kinds are checked
        check_value(32'(rdata), 32'(t.rdata), $sformatf("test %0d rdata", idx));
        check_value(32'(parity_err), 32'(t.perr), $sformatf("test %0d parity_err", idx));
        // Requester keeps req up for a while
        repeat (t.hold) begin
            @(posedge clk);
            @(negedge clk);
            check_value(32'(ack), 32'(1), $sformatf("test %0d ack during hold", idx));
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_value(32'(ack), 32'(1), $sformatf("test %0d ack before req seen low", idx));
        @(posedge clk);
        @(negedge clk);
        check_value(32'(ack), 32'(0), $sformatf("test %0d ack fall", idx));
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        rst_n        = 1'b0;
        req          = 1'b0;
        write        = 1'b0;
        addr         = '0;
        wdata        = '0;
        pwr_enable_b = 1'b1;
        pgcb_isol_en = 1'b0;
        load_tests();
        cycle_limit = tests.size() * cycles_per_test + limit_margin;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value(32'(ack), 32'(0), "reset ack");
        check_value(32'(rdata), 32'(0), "reset rdata");
        check_value(32'(parity_err), 32'(0), "reset parity_err");
        check_value(32'(pwr_enable_b_out), 32'(1), "reset pwr_enable_b_out");
        // Banks come out of their local reset a few edges later
        repeat (sync_stages + 1) @(posedge clk);
        if (errors == 0) begin
            foreach (tests[i]) begin
                run_test(i);
            end
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests.size(), checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== rtl/lsm_subsys_top.sv ====
// List-selection storage subsystem

`timescale 1ns/1ps

module lsm_subsys_top
    import lsm_geom_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    input  logic      write,
    input  cmd_addr_t addr,
    input  payload_t  wdata,
    output logic      ack,
    output payload_t  rdata,
    output logic      parity_err,
    input  logic      pwr_enable_b,
    input  logic      pgcb_isol_en,
    output logic      pwr_enable_b_out
);

    logic [num_banks-1:0] bank_we;
    logic [num_banks-1:0] bank_re;
    entry_addr_t          entry_addr;
    word_t                bank_wdata;
    bank_sel_t            rd_bank;
    word_t                bank_rdata [num_banks];
    // Entry 0 of the enable chain is the top input and the last entry leaves the block
    logic [num_banks:0]   pwr_chain;

    assign pwr_chain[0]     = pwr_enable_b;
    assign pwr_enable_b_out = pwr_chain[num_banks];

    lsm_req_decoder i_req_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .write      (write),
        .addr       (addr),
        .wdata      (wdata),
        .ack        (ack),
        .bank_we    (bank_we),
        .bank_re    (bank_re),
        .entry_addr (entry_addr),
        .bank_wdata (bank_wdata),
        .rd_bank    (rd_bank)
    );

    // --------------------
    // Bank array
    // --------------------

    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        lsm_rf_bank i_bank (
            .clk              (clk),
            .rst_n            (rst_n),
            .we               (bank_we[i]),
            .re               (bank_re[i]),
            .waddr            (entry_addr),
            .raddr            (entry_addr),
            .wdata            (bank_wdata),
            .pgcb_isol_en     (pgcb_isol_en),
            .pwr_enable_b_in  (pwr_chain[i]),
            .rdata            (bank_rdata[i]),
            .pwr_enable_b_out (pwr_chain[i+1])
        );
    end

    lsm_rsp_collector i_rsp_collector (
        .clk        (clk),
        .rst_n      (rst_n),
        .bank_re    (bank_re),
        .rd_bank    (rd_bank),
        .bank_rdata (bank_rdata),
        .rdata      (rdata),
        .parity_err (parity_err)
    );

endmodule

// ==== rtl/lsm_rsp_collector.sv ====
// Read response collector with parity check

`timescale 1ns/1ps

module lsm_rsp_collector
    import lsm_geom_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [num_banks-1:0] bank_re,
    input  bank_sel_t            rd_bank,
    input  word_t                bank_rdata [num_banks],
    output payload_t             rdata,
    output logic                 parity_err
);

    // --------------------
    // Strobe alignment
    // --------------------

    // Bank data appears one cycle after its read strobe
    logic [num_banks-1:0] re_d;
    bank_sel_t            bank_d;
    word_t                sel_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            re_d <= '0;
        end else begin
            re_d <= bank_re;
        end
    end

    // Bank index delayed to line up with re_d
    always_ff @(posedge clk) begin
        bank_d <= rd_bank;
    end

    // Word from the bank that was addressed
    assign sel_word = bank_rdata[bank_d];

    // --------------------
    // Held response
    // --------------------

    // Results stay put until the next read lands
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata      <= '0;
            parity_err <= 1'b0;
        end else if (|re_d) begin
            rdata <= sel_word[payload_w-1:0];
            // Even XOR means a bad word, which includes a clamped all-zero read
            parity_err <= ~^sel_word;
        end
    end

    // Delayed strobe and delayed bank index must agree on a single bank
    a_single_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        |re_d |-> ($onehot(re_d) && re_d[bank_d])
    ) else $error("read capture without a single matching bank strobe");

endmodule

// ==== rtl/lsm_req_decoder.sv ====
// Request decoder and bank strobe generator

`timescale 1ns/1ps

module lsm_req_decoder
    import lsm_geom_pkg::*;
    import lsm_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  logic                 write,
    input  cmd_addr_t            addr,
    input  payload_t             wdata,
    output logic                 ack,
    output logic [num_banks-1:0] bank_we,
    output logic [num_banks-1:0] bank_re,
    output entry_addr_t          entry_addr,
    output word_t                bank_wdata,
    output bank_sel_t            rd_bank
);

    req_state_t           state;
    logic                 cmd_write;
    logic [num_banks-1:0] bank_hit;

    // --------------------
    // Command capture
    // --------------------

    // Address, data and direction are taken when a new request is seen in idle
    always_ff @(posedge clk) begin
        if (state == idle && req) begin
            entry_addr <= addr[entry_w-1:0];
            rd_bank    <= addr[addr_w-1:entry_w];
            // Odd parity makes the XOR across all stored bits come out as one
            bank_wdata <= {~^wdata, wdata};
            cmd_write  <= write;
        end
    end

    // One-hot bank decode of the captured bank index
    always_comb begin
        bank_hit          = '0;
        bank_hit[rd_bank] = 1'b1;
    end

    // --------------------
    // Handshake FSM
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= idle;
            ack     <= 1'b0;
            bank_we <= '0;
            bank_re <= '0;
        end else begin
            // Strobes are single-cycle pulses unless issue sets them below
            bank_we <= '0;
            bank_re <= '0;
            case (state)
                idle: begin
                    if (req) begin
                        state <= issue;
                    end
                end
                issue: begin
                    // Exactly one bank sees either a write or a read strobe
                    bank_we <= cmd_write ? bank_hit : '0;
                    bank_re <= cmd_write ? '0 : bank_hit;
                    state   <= wait_data;
                end
                wait_data: begin
                    // Bank works on the strobe during this cycle
                    state <= hold_ack;
                end
                hold_ack: begin
                    if (!ack) begin
                        // Collector has the read result by now
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    a_strobe_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0({bank_we, bank_re})
    ) else $error("more than one bank strobe active");

    // The requester must still be holding req when the response is signalled
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req)
    ) else $error("ack raised without a pending request");

endmodule

// ==== rtl/lsm_rf_bank.sv ====
// Power-gated register-file bank

`timescale 1ns/1ps

module lsm_rf_bank
    import lsm_geom_pkg::*;
    import lsm_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic        re,
    input  entry_addr_t waddr,
    input  entry_addr_t raddr,
    input  word_t       wdata,
    input  logic        pgcb_isol_en,
    input  logic        pwr_enable_b_in,
    output word_t       rdata,
    output logic        pwr_enable_b_out
);

    // --------------------
    // Local reset
    // --------------------

    // Shift register that releases the bank reset a few cycles after rst_n
    logic [sync_stages-1:0] rst_pipe;
    logic                   bank_rst_n;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rst_pipe <= '0;
        end else begin
            rst_pipe <= {rst_pipe[sync_stages-2:0], 1'b1};
        end
    end

    // The last stage is the reset seen by the rest of the bank
    assign bank_rst_n = rst_pipe[sync_stages-1];

    // --------------------
    // Enable chain stage
    // --------------------

    // One flop per bank, so the enable ripples down the chain a cycle per bank
    always_ff @(posedge clk) begin
        if (!bank_rst_n) begin
            pwr_enable_b_out <= pwr_asleep;
        end else begin
            pwr_enable_b_out <= pwr_enable_b_in;
        end
    end

    // The array is powered while its own registered enable is low
    logic awake;
    assign awake = (pwr_enable_b_out != pwr_asleep);

    // --------------------
    // Storage array
    // --------------------

    word_t mem [bank_depth];
    word_t rd_q;

    // Writes to a sleeping array are lost but old contents stay in place
    always_ff @(posedge clk) begin
        if (we && awake) begin
            mem[waddr] <= wdata;
        end
    end

    // A powered-down array reads back as zeros
    always_ff @(posedge clk) begin
        if (re) begin
            rd_q <= awake ? mem[raddr] : '0;
        end
    end

    // Isolation clamp on the output side of the read register
    assign rdata = pgcb_isol_en ? '0 : rd_q;

    // The decoder must not strobe a bank whose local reset is still held
    a_no_access_in_reset: assert property (
        @(posedge clk) !bank_rst_n |-> !(we || re)
    ) else $error("bank strobed while its synchronized reset is active");

endmodule

// ==== rtl/lsm_ctrl_pkg.sv ====
// Request and power control definitions

package lsm_ctrl_pkg;

    // --------------------
    // Request FSM
    // --------------------

    // One command moves idle, issue, wait_data, hold_ack and back to idle
    typedef enum logic [1:0] {
        idle      = 2'd0,
        issue     = 2'd1,
        wait_data = 2'd2,
        hold_ack  = 2'd3
    } req_state_t;

    // --------------------
    // Power chain
    // --------------------

    // Flops in each bank's local reset synchronizer
    localparam int sync_stages = 2;
    // Level of the active-low enable that puts a bank to sleep
    localparam logic pwr_asleep = 1'b1;

endpackage

// ==== rtl/lsm_geom_pkg.sv ====
// Storage geometry definitions

package lsm_geom_pkg;

    // --------------------
    // Bank array shape
    // --------------------

    // Number of identical register-file banks
    localparam int num_banks  = 4;
    // Words held in each bank
    localparam int bank_depth = 8;
    // Payload carried by a command, parity excluded
    localparam int payload_w  = 16;
    // Stored word, payload plus one odd-parity bit on top
    localparam int word_w     = payload_w + 1;

    // --------------------
    // Address split
    // --------------------

    // Upper address bits select the bank
    localparam int bank_sel_w = $clog2(num_banks);
    // Lower address bits select the word inside a bank
    localparam int entry_w    = $clog2(bank_depth);
    // Full command address as seen on the request port
    localparam int addr_w     = bank_sel_w + entry_w;

    typedef logic [bank_sel_w-1:0] bank_sel_t;
    typedef logic [entry_w-1:0]    entry_addr_t;
    typedef logic [addr_w-1:0]     cmd_addr_t;
    typedef logic [payload_w-1:0]  payload_t;
    // Bit word_w-1 is the parity bit
    typedef logic [word_w-1:0]     word_t;

endpackage
